/* rtl/frame_buffer.sv */
// Store-and-forward buffer of output words
// Releases frames only once every word up to a clean frame end is stored

`timescale 1ns/100ps

module frame_buffer import mfb_pkg::*; #(
    parameter int BUF_WORDS = 32
) (
    input  logic         mfb_tx,
    input  logic         rst,
    input  mfb_tx_word_t pk,
    input  logic         pk_valid,
    output logic         pk_ready,
    output mfb_tx_word_t tx,
    output logic         tx_src_rdy,
    input  logic         tx_dst_rdy
);

    localparam int PTR_W = $clog2(BUF_WORDS);
    localparam int CNT_W = $clog2(BUF_WORDS + 1);

    mfb_tx_word_t     mem [BUF_WORDS];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    // Words held
    logic [CNT_W-1:0] used;
    // Stored frame ends with no new start behind them
    logic [CNT_W-1:0] frames;
    logic             wr_en;
    logic             rd_en;
    logic             wr_split;
    logic             head_split;
    logic             wr_eof;
    logic             rd_eof;

    ////////////////////////////////////////////////////////////
    // Flow control
    ////////////////////////////////////////////////////////////

    assign pk_ready = used != CNT_W'(BUF_WORDS);
    assign wr_en    = pk_valid && pk_ready;

    // Word ends one frame and opens the next
    assign wr_split = pk.sof && pk.eof && (pk.sof_pos > pk.eof_pos[5:4]);
    // Chained frames only count once the last of the chain is in
    assign wr_eof   = wr_en && pk.eof && !wr_split;

    assign tx = mem[rd_ptr];

    assign head_split = tx.sof && tx.eof && (tx.sof_pos > tx.eof_pos[5:4]);

    // Everything up to the next clean end is stored, so the run
    // of frames leaves without gaps of its own
    assign tx_src_rdy = frames != '0;
    assign rd_en      = tx_src_rdy && tx_dst_rdy;
    assign rd_eof     = rd_en && tx.eof && !head_split;

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge mfb_tx) begin
        if (wr_en) begin
            mem[wr_ptr] <= pk;
        end
    end

    // Pointers and counts
    always_ff @(posedge mfb_tx) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            used   <= '0;
            frames <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(BUF_WORDS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(BUF_WORDS - 1)) ? '0 : rd_ptr + 1'b1;
            end

            if (wr_en && !rd_en) begin
                used <= used + 1'b1;
            end else if (rd_en && !wr_en) begin
                used <= used - 1'b1;
            end

            // Visible to the reader one cycle after the end is written
            if (wr_eof && !rd_eof) begin
                frames <= frames + 1'b1;
            end else if (rd_eof && !wr_eof) begin
                frames <= frames - 1'b1;
            end
        end
    end

endmodule

/* rtl/mfb_pkg.sv */
// Bus word formats for both MFB ports
// Input side: one region, eight 8-byte blocks
// Output side: one region, four 16-byte blocks (LBUS friendly)

package mfb_pkg;

    ////////////////////////////////////////////////////////////
    // Geometry
    ////////////////////////////////////////////////////////////

    // Bytes per bus word, same on both sides
    localparam int word_bytes = 64;

    // Input block granularity for sof_pos
    localparam int rx_block_bytes = 8;

    // Output block granularity for sof_pos
    localparam int tx_block_bytes = 16;

    ////////////////////////////////////////////////////////////
    // Word structs
    ////////////////////////////////////////////////////////////

    // Input word
    // Byte i of the word sits at data[8*i +: 8]
    typedef struct packed {
        logic [8*word_bytes-1:0] data;
        logic                    sof;
        logic                    eof;
        // Index of the block holding the frame start
        logic [2:0]              sof_pos;
        // Byte index of the last byte of the ending frame
        logic [5:0]              eof_pos;
    } mfb_rx_word_t;

    // Output word, coarser start position
    typedef struct packed {
        logic [8*word_bytes-1:0] data;
        logic                    sof;
        logic                    eof;
        logic [1:0]              sof_pos;
        logic [5:0]              eof_pos;
    } mfb_tx_word_t;

endpackage

/* rtl/mfb_to_lbus_reconf.sv */
// MFB to LBUS-friendly MFB reconfigurator, top level
// Splitter, block packer and frame buffer in a chain

`timescale 1ns/100ps

module mfb_to_lbus_reconf import mfb_pkg::*, reconf_pkg::*; #(
    // Frame buffer depth in output words
    parameter int BUF_WORDS = 32
) (
    input  logic         mfb_tx,
    input  logic         rst,
    input  mfb_rx_word_t rx,
    input  logic         rx_src_rdy,
    output logic         rx_dst_rdy,
    output mfb_tx_word_t tx,
    output logic         tx_src_rdy,
    input  logic         tx_dst_rdy
);

    // Splitter to packer
    seg_t         seg;
    logic         seg_valid;
    logic         seg_ready;

    // Packer to buffer
    mfb_tx_word_t pk;
    logic         pk_valid;
    logic         pk_ready;

    rx_segmenter u_segmenter (
        .mfb_tx     (mfb_tx),
        .rst        (rst),
        .rx         (rx),
        .rx_src_rdy (rx_src_rdy),
        .rx_dst_rdy (rx_dst_rdy),
        .seg        (seg),
        .seg_valid  (seg_valid),
        .seg_ready  (seg_ready)
    );

    tx_block_packer u_packer (
        .mfb_tx    (mfb_tx),
        .rst       (rst),
        .seg       (seg),
        .seg_valid (seg_valid),
        .seg_ready (seg_ready),
        .pk        (pk),
        .pk_valid  (pk_valid),
        .pk_ready  (pk_ready)
    );

    frame_buffer #(
        .BUF_WORDS (BUF_WORDS)
    ) u_buffer (
        .mfb_tx     (mfb_tx),
        .rst        (rst),
        .pk         (pk),
        .pk_valid   (pk_valid),
        .pk_ready   (pk_ready),
        .tx         (tx),
        .tx_src_rdy (tx_src_rdy),
        .tx_dst_rdy (tx_dst_rdy)
    );

endmodule

/* rtl/reconf_pkg.sv */
// Internal segment format between splitter and packer
// Frame-start alignment constant

package reconf_pkg;

    ////////////////////////////////////////////////////////////
    // Segment of a single frame, left aligned
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        // First valid byte always at byte 0
        logic [8*mfb_pkg::word_bytes-1:0] data;
        // Valid bytes, 1 to 64
        logic [6:0]                       len;
        // Segment opens a frame
        logic                             sof;
        // Segment closes a frame
        logic                             eof;
    } seg_t;

    // Every frame start lands on this byte boundary in the output word
    localparam int align_bytes = 16;

endpackage

/* rtl/rx_segmenter.sv */
// Input word splitter
// Cuts each accepted word into one or two per-frame segments,
// each shifted so its first byte is byte 0

`timescale 1ns/100ps

module rx_segmenter import mfb_pkg::*, reconf_pkg::*; (
    input  logic         mfb_tx,
    input  logic         rst,
    input  mfb_rx_word_t rx,
    input  logic         rx_src_rdy,
    output logic         rx_dst_rdy,
    output seg_t         seg,
    output logic         seg_valid,
    input  logic         seg_ready
);

    logic       in_frame;
    seg_t       held;
    logic       held_valid;
    logic       out_free;
    logic       rx_take;
    logic       split;
    logic       has_seg;
    logic [6:0] sof_bytes;
    logic [9:0] sof_shift;
    logic [6:0] eof_len;
    seg_t       head_seg;
    seg_t       tail_seg;

    ////////////////////////////////////////////////////////////
    // Handshake
    ////////////////////////////////////////////////////////////

    assign out_free   = !seg_valid || seg_ready;
    // Second half of a split word blocks new input for a cycle
    assign rx_dst_rdy = out_free && !held_valid;
    assign rx_take    = rx_src_rdy && rx_dst_rdy;

    ////////////////////////////////////////////////////////////
    // Word decode
    ////////////////////////////////////////////////////////////

    // Start offset in bytes and in bits
    assign sof_bytes = 7'(rx.sof_pos * rx_block_bytes);
    assign sof_shift = {sof_bytes, 3'b000};
    assign eof_len   = {1'b0, rx.eof_pos} + 7'd1;

    // Open frame plus both flags means end of old, start of new
    assign split   = in_frame && rx.sof && rx.eof;
    // Idle gap words carry nothing
    assign has_seg = in_frame || rx.sof;

    always_comb begin
        // Start part, runs to the end of the word
        tail_seg.data = rx.data >> sof_shift;
        tail_seg.len  = 7'(word_bytes) - sof_bytes;
        tail_seg.sof  = 1'b1;
        tail_seg.eof  = 1'b0;

        // Default is a plain start-only word
        head_seg = tail_seg;
        if (split) begin
            // Old frame closes first, already at byte 0
            head_seg.data = rx.data;
            head_seg.len  = eof_len;
            head_seg.sof  = 1'b0;
            head_seg.eof  = 1'b1;
        end else if (in_frame) begin
            // Continuation or end-only word
            head_seg.data = rx.data;
            head_seg.len  = rx.eof ? eof_len : 7'(word_bytes);
            head_seg.sof  = 1'b0;
            head_seg.eof  = rx.eof;
        end else if (rx.eof) begin
            // Whole frame inside one word
            head_seg.len = eof_len - sof_bytes;
            head_seg.eof = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Control state
    ////////////////////////////////////////////////////////////

    always_ff @(posedge mfb_tx) begin
        if (rst) begin
            in_frame   <= 1'b0;
            held_valid <= 1'b0;
            seg_valid  <= 1'b0;
        end else begin
            // Both flags together leave the frame state as it was
            if (rx_take && rx.sof && !rx.eof) begin
                in_frame <= 1'b1;
            end else if (rx_take && rx.eof && !rx.sof) begin
                in_frame <= 1'b0;
            end

            if (held_valid && out_free) begin
                held_valid <= 1'b0;
            end else if (rx_take && split) begin
                held_valid <= 1'b1;
            end

            if (out_free) begin
                seg_valid <= held_valid || (rx_take && has_seg);
            end
        end
    end

    // Segment payload
    always_ff @(posedge mfb_tx) begin
        if (out_free) begin
            // Held start half goes out ahead of anything new
            seg <= held_valid ? held : head_seg;
        end
        if (rx_take) begin
            held <= tail_seg;
        end
    end

endmodule

/* rtl/tx_block_packer.sv */
// Segment packer for the output format
// Places segments into 64-byte words, frame starts on 16-byte
// boundaries, at most one start and one end per word

`timescale 1ns/100ps

module tx_block_packer import mfb_pkg::*, reconf_pkg::*; (
    input  logic         mfb_tx,
    input  logic         rst,
    input  seg_t         seg,
    input  logic         seg_valid,
    output logic         seg_ready,
    output mfb_tx_word_t pk,
    output logic         pk_valid,
    input  logic         pk_ready
);

    // Word under construction and its fill level
    mfb_tx_word_t            acc;
    logic [6:0]              acc_off;

    logic                    out_free;
    logic [6:0]              base;
    logic [7:0]              end_pos;
    logic                    eof_here;
    logic                    fits_mid;
    logic                    flush;
    logic                    place;
    logic                    fill;
    logic                    drain;
    logic                    emit;
    logic [8*word_bytes-1:0] keep_mask;
    logic [8*word_bytes-1:0] merged;
    logic [8*word_bytes-1:0] carry;
    mfb_tx_word_t            built;
    mfb_tx_word_t            emit_word;

    ////////////////////////////////////////////////////////////
    // Placement
    ////////////////////////////////////////////////////////////

    assign out_free = !pk_valid || pk_ready;

    // Frame start rounds up to the next aligned byte
    assign base = seg.sof ?
        7'(((acc_off + align_bytes - 1) / align_bytes) * align_bytes) : acc_off;
    assign end_pos  = {1'b0, base} + {1'b0, seg.len};
    assign fill     = end_pos >= 8'(word_bytes);
    assign eof_here = seg.eof && (end_pos <= 8'(word_bytes));

    // New frame may share a word with the previous end only when
    // it runs past the word, so its own end lands later
    assign fits_mid = acc.eof && !acc.sof && !base[6] &&
                      ((end_pos > 8'(word_bytes)) ||
                       ((end_pos == 8'(word_bytes)) && !seg.eof));

    // Start that cannot share this word, push the word out first
    assign flush = seg_valid && seg.sof && (acc_off != 7'd0) && !fits_mid;

    assign seg_ready = out_free && !flush;
    assign place     = seg_valid && seg_ready;
    // Nothing offered behind a finished frame
    assign drain     = !seg_valid && acc.eof;
    assign emit      = (place && fill) || ((flush || drain) && out_free);

    // Only bytes below the fill level survive in the old word
    assign keep_mask = ~({(8*word_bytes){1'b1}} << {acc_off, 3'b000});
    assign merged    = (acc.data & keep_mask) | (seg.data << {base, 3'b000});
    // Bytes past the word end start the next one
    assign carry     = seg.data >> {7'(word_bytes) - base, 3'b000};

    always_comb begin
        built      = acc;
        built.data = merged;
        if (seg.sof) begin
            built.sof     = 1'b1;
            built.sof_pos = 2'(base / tx_block_bytes);
        end
        if (eof_here) begin
            built.eof     = 1'b1;
            built.eof_pos = 6'(end_pos - 8'd1);
        end
        emit_word = place ? built : acc;
    end

    ////////////////////////////////////////////////////////////
    // Accumulator
    ////////////////////////////////////////////////////////////

    always_ff @(posedge mfb_tx) begin
        if (rst) begin
            acc_off <= '0;
            acc.sof <= 1'b0;
            acc.eof <= 1'b0;
        end else if (place && fill) begin
            // Word complete, overflow becomes the new word
            acc_off     <= 7'(end_pos - 8'(word_bytes));
            acc.data    <= carry;
            acc.sof     <= 1'b0;
            acc.eof     <= seg.eof && !eof_here;
            acc.eof_pos <= 6'(end_pos - 8'(word_bytes) - 8'd1);
        end else if (place) begin
            acc_off <= end_pos[6:0];
            acc     <= built;
        end else if (emit) begin
            // Flushed or drained, start empty
            acc_off <= '0;
            acc.sof <= 1'b0;
            acc.eof <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge mfb_tx) begin
        if (rst) begin
            pk_valid <= 1'b0;
        end else if (out_free) begin
            pk_valid <= emit;
        end
    end

    always_ff @(posedge mfb_tx) begin
        if (emit) begin
            pk <= emit_word;
        end
    end

endmodule

/* tests/tb_checker.sv */
// Output monitor: format rules of the LBUS-friendly bus
// Frame rebuild and byte compare against the model queues

`timescale 1ns/100ps

module tb_checker import mfb_pkg::*; (
    input  logic         mfb_tx,
    input  logic         rst,
    input  mfb_tx_word_t tx,
    input  logic         tx_src_rdy,
    input  logic         tx_dst_rdy
);

    // Model of the frames still expected, in order
    logic [7:0] exp_bytes [$];
    int         exp_lens [$];
    // Frame being rebuilt from the output
    logic [7:0] got [$];
    logic       in_frame = 1'b0;
    logic       gap_noted = 1'b0;

    int frames_seen = 0;
    int errors      = 0;
    int data_errs   = 0;
    int gap_errs    = 0;
    int sof_errs    = 0;
    int follow_errs = 0;
    int order_errs  = 0;

    task automatic expect_byte(input logic [7:0] b);
        exp_bytes.push_back(b);
    endtask

    task automatic expect_len(input int len);
        exp_lens.push_back(len);
    endtask

    task automatic take_bytes(input int lo, input int hi);
        for (int i = lo; i <= hi; i++) begin
            got.push_back(tx.data[8*i +: 8]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Frame compare
    ////////////////////////////////////////////////////////////

    task automatic close_frame();
        int         len;
        logic [7:0] e;
        logic       bad;
        if (exp_lens.size() == 0) begin
            $display("Output frame %0d arrived with no input frame left to match", frames_seen);
            order_errs++;
            errors++;
        end else begin
            len = exp_lens.pop_front();
            bad = 1'b0;
            if (got.size() != len) begin
                $display("[FAIL] frame %0d length: got %h expected %h",
                         frames_seen, got.size(), len);
                data_errs++;
                errors++;
            end
            for (int i = 0; i < len; i++) begin
                e = exp_bytes.pop_front();
                // First wrong byte of a frame only
                if (!bad && i < got.size() && got[i] !== e) begin
                    $display("[FAIL] tx.data frame %0d byte %0d: got %h expected %h",
                             frames_seen, i, got[i], e);
                    bad = 1'b1;
                    data_errs++;
                    errors++;
                end
            end
        end
        got.delete();
        gap_noted = 1'b0;
        frames_seen++;
    endtask

    ////////////////////////////////////////////////////////////
    // Bus watch, sampled half a cycle before each edge
    ////////////////////////////////////////////////////////////

    always @(negedge mfb_tx) begin : watch
        int start;
        start = tx_block_bytes * tx.sof_pos;
        if (!rst) begin
            // Stored frame must flow while the receiver takes it
            if (in_frame && !tx_src_rdy && tx_dst_rdy) begin
                if (!gap_noted) begin
                    $display("Output valid dropped inside frame %0d while ready was high",
                             frames_seen);
                end
                gap_noted = 1'b1;
                gap_errs++;
                errors++;
            end
            if (tx_src_rdy && tx_dst_rdy) begin
                if (tx.sof && !tx.eof && tx.sof_pos != 2'd0) begin
                    $display("[FAIL] tx.sof_pos: got %h expected %h", tx.sof_pos, 2'd0);
                    sof_errs++;
                    errors++;
                end
                if (in_frame) begin
                    if (tx.eof) begin
                        take_bytes(0, tx.eof_pos);
                        close_frame();
                        in_frame = 1'b0;
                    end else begin
                        if (tx.sof) begin
                            $display("Frame start seen while frame %0d is still open",
                                     frames_seen);
                            data_errs++;
                            errors++;
                        end
                        take_bytes(0, word_bytes - 1);
                    end
                    if (tx.sof && tx.eof) begin
                        // Next start sits in the block right after the end block
                        if (int'(tx.sof_pos) != int'(tx.eof_pos) / tx_block_bytes + 1) begin
                            $display("[FAIL] tx.sof_pos: got %h expected %h",
                                     tx.sof_pos, tx.eof_pos / tx_block_bytes + 1);
                            follow_errs++;
                            errors++;
                        end
                        take_bytes(start, word_bytes - 1);
                        in_frame = 1'b1;
                    end
                end else if (tx.sof) begin
                    if (tx.eof) begin
                        if (int'(tx.eof_pos) < start) begin
                            $display("Single-word frame %0d ends before it starts",
                                     frames_seen);
                            data_errs++;
                            errors++;
                        end
                        take_bytes(start, tx.eof_pos);
                        close_frame();
                    end else begin
                        take_bytes(start, word_bytes - 1);
                        in_frame = 1'b1;
                    end
                end else begin
                    $display("Data word transferred outside of any frame");
                    data_errs++;
                    errors++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Closing summary, one line per behavior
    ////////////////////////////////////////////////////////////

    task automatic report(input int num_frames);
        if (frames_seen != num_frames) begin
            $display("[FAIL] frame count: got %h expected %h", frames_seen, num_frames);
            order_errs++;
            errors++;
        end
        if (in_frame) begin
            $display("Last output frame never reached its end");
            order_errs++;
            errors++;
        end
        $display("data integrity     : %s, %0d errors", data_errs ? "fail" : "pass", data_errs);
        $display("no gaps in frames  : %s, %0d errors", gap_errs ? "fail" : "pass", gap_errs);
        $display("start at block 0   : %s, %0d errors", sof_errs ? "fail" : "pass", sof_errs);
        $display("start follows end  : %s, %0d errors",
                 follow_errs ? "fail" : "pass", follow_errs);
        $display("order and count    : %s, %0d errors",
                 order_errs ? "fail" : "pass", order_errs);
    endtask

endmodule

/* tests/tb_top.sv */
// Testbench top: clock, reset, xorshift frame source, input driver
// Random output back-pressure, DUT and checker instances, run control

`timescale 1ns/100ps

module tb_top import mfb_pkg::*; ();

    localparam int num_frames = 300;
    localparam int max_len    = 400;
    localparam logic [31:0] seed = 32'h450d_4e44;
    // Eight output words per largest frame, times four for idle and stalls
    localparam int max_cycles = num_frames * 8 * 4 + 1000;

    logic         mfb_tx;
    logic         rst;
    mfb_rx_word_t rx;
    logic         rx_src_rdy;
    logic         rx_dst_rdy;
    mfb_tx_word_t tx;
    logic         tx_src_rdy;
    logic         tx_dst_rdy;

    // Driver and back-pressure each keep their own random state
    logic [31:0]  drv_state;
    logic [31:0]  rdy_state;
    int           frame_lens [$];
    logic [7:0]   frame_bytes [$];

    mfb_to_lbus_reconf #(
        .BUF_WORDS (32)
    ) dut (
        .mfb_tx     (mfb_tx),
        .rst        (rst),
        .rx         (rx),
        .rx_src_rdy (rx_src_rdy),
        .rx_dst_rdy (rx_dst_rdy),
        .tx         (tx),
        .tx_src_rdy (tx_src_rdy),
        .tx_dst_rdy (tx_dst_rdy)
    );

    tb_checker chk (
        .mfb_tx     (mfb_tx),
        .rst        (rst),
        .tx         (tx),
        .tx_src_rdy (tx_src_rdy),
        .tx_dst_rdy (tx_dst_rdy)
    );

    ////////////////////////////////////////////////////////////
    // Random numbers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Next driver value in 0 .. n-1
    function automatic int rand_below(input int n);
        drv_state = xorshift(drv_state);
        return int'(drv_state % 32'(n));
    endfunction

    ////////////////////////////////////////////////////////////
    // Input driver
    ////////////////////////////////////////////////////////////

    // Present one word, with an optional idle gap first
    task automatic send_word(input mfb_rx_word_t w);
        logic taken;
        if (rand_below(4) == 0) begin
            rx_src_rdy = 1'b0;
            repeat (1 + rand_below(3)) begin
                @(posedge mfb_tx);
                #2;
            end
        end
        rx         = w;
        rx_src_rdy = 1'b1;
        taken      = 1'b0;
        while (!taken) begin
            // Ready is settled half a cycle before the edge
            @(negedge mfb_tx);
            taken = rx_dst_rdy;
            @(posedge mfb_tx);
            #2;
        end
    endtask

    // Pack all frames into input words
    task automatic drive_frames();
        mfb_rx_word_t w;
        int           pos;
        int           start;
        int           idx;
        int           len;
        w   = '0;
        pos = 0;
        idx = 0;
        for (int f = 0; f < num_frames; f++) begin
            len = frame_lens[f];
            if (pos != 0) begin
                // Shared word only behind an end, and the new frame must leave it
                start = ((pos + 7) / 8) * 8;
                if (w.sof || start >= word_bytes || start + len <= word_bytes ||
                    rand_below(2) == 0) begin
                    send_word(w);
                    w   = '0;
                    pos = 0;
                end
            end
            if (pos == 0) begin
                start = rx_block_bytes * rand_below(8);
            end
            w.sof     = 1'b1;
            w.sof_pos = 3'(start / rx_block_bytes);
            pos       = start;
            for (int b = 0; b < len; b++) begin
                if (pos == word_bytes) begin
                    send_word(w);
                    w   = '0;
                    pos = 0;
                end
                w.data[8*pos +: 8] = frame_bytes[idx];
                idx++;
                pos++;
            end
            w.eof     = 1'b1;
            w.eof_pos = 6'(pos - 1);
        end
        send_word(w);
        rx_src_rdy = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Clock, back-pressure, watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        mfb_tx = 1'b0;
        forever #20 mfb_tx = ~mfb_tx;
    end

    // Receiver holds off about 30 percent of cycles
    initial begin
        forever begin
            @(posedge mfb_tx);
            #2;
            rdy_state  = xorshift(rdy_state);
            tx_dst_rdy = (rdy_state % 10) >= 3;
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge mfb_tx);
            cycles++;
        end
        $display("Timeout: run stopped after %0d cycles, %0d of %0d frames received",
                 cycles, chk.frames_seen, num_frames);
        $display("TEST FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst        = 1'b1;
        rx         = '0;
        rx_src_rdy = 1'b0;
        tx_dst_rdy = 1'b0;
        drv_state  = seed;
        rdy_state  = seed ^ 32'h5a5a_a5a5;

        // Frames go to the driver and to the checker model alike
        for (int f = 0; f < num_frames; f++) begin
            frame_lens.push_back(1 + rand_below(max_len));
            chk.expect_len(frame_lens[f]);
            for (int b = 0; b < frame_lens[f]; b++) begin
                frame_bytes.push_back(8'(rand_below(256)));
                chk.expect_byte(frame_bytes[frame_bytes.size() - 1]);
            end
        end

        repeat (16) @(posedge mfb_tx);
        #2;
        rst = 1'b0;

        drive_frames();
        while (chk.frames_seen < num_frames) begin
            @(posedge mfb_tx);
        end
        // Room for any stray extra word
        repeat (50) @(posedge mfb_tx);

        chk.report(num_frames);
        $display("frames received %0d of %0d, errors %0d",
                 chk.frames_seen, num_frames, chk.errors);
        if (chk.errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
rtl/mfb_pkg.sv
rtl/reconf_pkg.sv
rtl/rx_segmenter.sv
rtl/tx_block_packer.sv
rtl/frame_buffer.sv
rtl/mfb_to_lbus_reconf.sv
tests/tb_checker.sv
tests/tb_top.sv
